//--- hdl/pipe_pkg.sv
package pipe_pkg;

    // field widths of the instruction format
    localparam int addr_w    = 16;
    localparam int word_w    = 32;
    localparam int operand_w = 8;
    localparam int opcode_w  = 2;

    typedef logic [addr_w-1:0]    addr_t;
    typedef logic [word_w-1:0]    word_t;
    typedef logic [operand_w-1:0] operand_t;

    typedef enum logic [opcode_w-1:0] {
        OP_ADD   = 2'd0,
        OP_SUB   = 2'd1,
        OP_LOAD  = 2'd2,
        OP_STORE = 2'd3
    } opcode_e;

    // opcode on top, operands in the low half
    typedef struct packed {
        opcode_e                                    opcode;
        logic [word_w-opcode_w-2*operand_w-1:0]     unused;
        operand_t                                   a;
        operand_t                                   b;
    } instr_t;

    typedef struct packed {
        logic load_pc;
        logic load_if_id;
        logic load_id_ex;
        logic load_ex_mem;
        logic load_mem_wb;
    } hazard_ctrl_t;

    typedef struct packed {
        addr_t   pc;
        opcode_e opcode;
        // alu result or data address
        addr_t   addr;
        word_t   store_data;
    } ex_mem_t;

    typedef struct packed {
        addr_t   pc;
        opcode_e opcode;
        word_t   result;
    } retire_t;

    localparam addr_t pc_step  = 16'd4;
    localparam addr_t reset_pc = 16'd0;

endpackage

//--- hdl/fetch_unit.sv
module fetch_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   imem_resp_i,
    input  pipe_pkg::word_t        imem_rdata_i,
    input  pipe_pkg::hazard_ctrl_t hazard_ctrl_i,
    output logic                   imem_read_o,
    output pipe_pkg::addr_t        imem_addr_o,
    output pipe_pkg::instr_t       if_id_o,
    output pipe_pkg::addr_t        if_id_pc_o
);

    pipe_pkg::addr_t pc;
    pipe_pkg::word_t hold_word;
    logic            held;
    logic            active;

    // no new request while a fetched word waits for a step
    assign imem_read_o = active && !held;
    assign imem_addr_o = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc     <= pipe_pkg::reset_pc;
            held   <= 1'b0;
            active <= 1'b0;
        end else begin
            active <= 1'b1;
            if (hazard_ctrl_i.load_pc) begin
                pc <= pc + pipe_pkg::pc_step;
            end
            if (hazard_ctrl_i.load_if_id) begin
                held <= 1'b0;
            end else if (imem_resp_i) begin
                held <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (imem_resp_i && !hazard_ctrl_i.load_if_id) begin
            hold_word <= imem_rdata_i;
        end
        if (hazard_ctrl_i.load_if_id) begin
            if_id_o    <= held ? pipe_pkg::instr_t'(hold_word) : pipe_pkg::instr_t'(imem_rdata_i);
            if_id_pc_o <= pc;
        end
    end

endmodule

//--- hdl/hazard_ctrl_unit.sv
module hazard_ctrl_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   imem_resp_i,
    input  logic                   dmem_read_i,
    input  logic                   dmem_write_i,
    input  logic                   dmem_resp_i,
    output pipe_pkg::hazard_ctrl_t hazard_ctrl_o,
    output logic                   id_valid_o,
    output logic                   ex_valid_o,
    output logic                   mem_valid_o,
    output logic                   wb_valid_o
);

    typedef enum logic [1:0] {
        IF_READY,
        IF_HELD,
        IF_LOAD
    } if_state_e;

    typedef enum logic {
        MEM_READY,
        MEM_WAIT
    } mem_state_e;

    if_state_e  if_state;
    if_state_e  if_next_state;
    mem_state_e mem_state;
    mem_state_e mem_next_state;

    logic run;
    logic mem_req;
    logic mem_stall;
    logic step;
    logic fetch_take;

    assign mem_req = dmem_read_i || dmem_write_i;

    // an unanswered data request freezes every stage
    assign mem_stall = ((mem_state == MEM_WAIT) || mem_req) && !dmem_resp_i;
    assign step      = run && !mem_stall;

    // a fetched word enters ID only together with a step
    assign fetch_take = step && (imem_resp_i || (if_state == IF_HELD));

    always_ff @(posedge clk) begin
        if (rst) begin
            if_state    <= IF_READY;
            mem_state   <= MEM_READY;
            run         <= 1'b0;
            id_valid_o  <= 1'b0;
            ex_valid_o  <= 1'b0;
            mem_valid_o <= 1'b0;
            wb_valid_o  <= 1'b0;
        end else begin
            if_state  <= if_next_state;
            mem_state <= mem_next_state;
            run       <= 1'b1;
            // bubbles travel with the valid chain
            if (step) begin
                id_valid_o  <= fetch_take;
                ex_valid_o  <= id_valid_o;
                mem_valid_o <= ex_valid_o;
                wb_valid_o  <= mem_valid_o;
            end
        end
    end

    always_comb begin
        if_next_state = if_state;
        case (if_state)
            IF_READY, IF_LOAD: begin
                if (imem_resp_i) begin
                    if_next_state = step ? IF_LOAD : IF_HELD;
                end else begin
                    if_next_state = IF_READY;
                end
            end
            IF_HELD: begin
                if (step) begin
                    if_next_state = IF_LOAD;
                end
            end
            default: if_next_state = IF_READY;
        endcase
    end

    always_comb begin
        mem_next_state = mem_state;
        case (mem_state)
            MEM_READY: begin
                if (mem_req && !dmem_resp_i) begin
                    mem_next_state = MEM_WAIT;
                end
            end
            MEM_WAIT: begin
                if (dmem_resp_i) begin
                    mem_next_state = MEM_READY;
                end
            end
            default: mem_next_state = MEM_READY;
        endcase
    end

    always_comb begin
        hazard_ctrl_o.load_pc     = fetch_take;
        hazard_ctrl_o.load_if_id  = fetch_take;
        hazard_ctrl_o.load_id_ex  = step;
        hazard_ctrl_o.load_ex_mem = step;
        hazard_ctrl_o.load_mem_wb = step;
    end

endmodule

//--- hdl/execute_unit.sv
module execute_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  pipe_pkg::hazard_ctrl_t hazard_ctrl_i,
    input  pipe_pkg::instr_t       if_id_i,
    input  pipe_pkg::addr_t        if_id_pc_i,
    output pipe_pkg::ex_mem_t      ex_mem_o
);

    pipe_pkg::opcode_e  id_ex_op;
    pipe_pkg::operand_t id_ex_a;
    pipe_pkg::operand_t id_ex_b;
    pipe_pkg::addr_t    id_ex_pc;
    pipe_pkg::addr_t    a_ext;
    pipe_pkg::addr_t    b_ext;
    pipe_pkg::addr_t    alu_out;

    assign a_ext = {{(pipe_pkg::addr_w - pipe_pkg::operand_w){1'b0}}, id_ex_a};
    assign b_ext = {{(pipe_pkg::addr_w - pipe_pkg::operand_w){1'b0}}, id_ex_b};

    always_comb begin
        case (id_ex_op)
            pipe_pkg::OP_SUB: alu_out = a_ext - b_ext;
            // add, and the address of loads and stores
            default: alu_out = a_ext + b_ext;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex_op        <= pipe_pkg::OP_ADD;
            ex_mem_o.opcode <= pipe_pkg::OP_ADD;
        end else begin
            if (hazard_ctrl_i.load_id_ex) begin
                id_ex_op <= if_id_i.opcode;
                id_ex_a  <= if_id_i.a;
                id_ex_b  <= if_id_i.b;
                id_ex_pc <= if_id_pc_i;
            end
            if (hazard_ctrl_i.load_ex_mem) begin
                ex_mem_o.pc         <= id_ex_pc;
                ex_mem_o.opcode     <= id_ex_op;
                ex_mem_o.addr       <= alu_out;
                ex_mem_o.store_data <= {{(pipe_pkg::word_w - pipe_pkg::operand_w){1'b0}}, id_ex_b};
            end
        end
    end

endmodule

//--- hdl/mem_access_unit.sv
module mem_access_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mem_valid_i,
    input  logic                   wb_valid_i,
    input  pipe_pkg::hazard_ctrl_t hazard_ctrl_i,
    input  pipe_pkg::ex_mem_t      ex_mem_i,
    input  logic                   dmem_resp_i,
    input  pipe_pkg::word_t        dmem_rdata_i,
    output logic                   dmem_read_o,
    output logic                   dmem_write_o,
    output pipe_pkg::addr_t        dmem_addr_o,
    output pipe_pkg::word_t        dmem_wdata_o,
    output logic                   retire_valid_o,
    output pipe_pkg::retire_t      retire_o
);

    logic            is_load;
    logic            is_store;
    logic            fresh;
    pipe_pkg::word_t wb_result;

    assign is_load  = (ex_mem_i.opcode == pipe_pkg::OP_LOAD);
    assign is_store = (ex_mem_i.opcode == pipe_pkg::OP_STORE);

    assign dmem_read_o  = mem_valid_i && is_load;
    assign dmem_write_o = mem_valid_i && is_store;
    assign dmem_addr_o  = ex_mem_i.addr;
    assign dmem_wdata_o = ex_mem_i.store_data;

    always_comb begin
        case (ex_mem_i.opcode)
            pipe_pkg::OP_LOAD:  wb_result = dmem_rdata_i;
            pipe_pkg::OP_STORE: wb_result = ex_mem_i.store_data;
            default: wb_result = {{(pipe_pkg::word_w - pipe_pkg::addr_w){1'b0}}, ex_mem_i.addr};
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fresh <= 1'b0;
        end else begin
            fresh <= hazard_ctrl_i.load_mem_wb;
        end
    end

    always_ff @(posedge clk) begin
        if (hazard_ctrl_i.load_mem_wb) begin
            retire_o.pc     <= ex_mem_i.pc;
            retire_o.opcode <= ex_mem_i.opcode;
            retire_o.result <= wb_result;
        end
    end

    // one cycle per newly loaded MEM/WB entry
    assign retire_valid_o = fresh && wb_valid_i;

endmodule

//--- hdl/pipe_top.sv
module pipe_top (
    input  logic              clk,
    input  logic              rst,
    output logic              imem_read_o,
    output pipe_pkg::addr_t   imem_addr_o,
    input  logic              imem_resp_i,
    input  pipe_pkg::word_t   imem_rdata_i,
    output logic              dmem_read_o,
    output logic              dmem_write_o,
    output pipe_pkg::addr_t   dmem_addr_o,
    output pipe_pkg::word_t   dmem_wdata_o,
    input  logic              dmem_resp_i,
    input  pipe_pkg::word_t   dmem_rdata_i,
    output logic              retire_valid_o,
    output pipe_pkg::retire_t retire_o
);

    pipe_pkg::hazard_ctrl_t hazard_ctrl;
    pipe_pkg::instr_t       if_id;
    pipe_pkg::addr_t        if_id_pc;
    pipe_pkg::ex_mem_t      ex_mem;
    logic                   mem_valid;
    logic                   wb_valid;

    fetch_unit u_fetch (
        .clk           (clk),
        .rst           (rst),
        .imem_resp_i   (imem_resp_i),
        .imem_rdata_i  (imem_rdata_i),
        .hazard_ctrl_i (hazard_ctrl),
        .imem_read_o   (imem_read_o),
        .imem_addr_o   (imem_addr_o),
        .if_id_o       (if_id),
        .if_id_pc_o    (if_id_pc)
    );

    // ID and EX valid bits stay inside the controller
    hazard_ctrl_unit u_hazard (
        .clk           (clk),
        .rst           (rst),
        .imem_resp_i   (imem_resp_i),
        .dmem_read_i   (dmem_read_o),
        .dmem_write_i  (dmem_write_o),
        .dmem_resp_i   (dmem_resp_i),
        .hazard_ctrl_o (hazard_ctrl),
        .id_valid_o    (),
        .ex_valid_o    (),
        .mem_valid_o   (mem_valid),
        .wb_valid_o    (wb_valid)
    );

    execute_unit u_execute (
        .clk           (clk),
        .rst           (rst),
        .hazard_ctrl_i (hazard_ctrl),
        .if_id_i       (if_id),
        .if_id_pc_i    (if_id_pc),
        .ex_mem_o      (ex_mem)
    );

    mem_access_unit u_mem (
        .clk            (clk),
        .rst            (rst),
        .mem_valid_i    (mem_valid),
        .wb_valid_i     (wb_valid),
        .hazard_ctrl_i  (hazard_ctrl),
        .ex_mem_i       (ex_mem),
        .dmem_resp_i    (dmem_resp_i),
        .dmem_rdata_i   (dmem_rdata_i),
        .dmem_read_o    (dmem_read_o),
        .dmem_write_o   (dmem_write_o),
        .dmem_addr_o    (dmem_addr_o),
        .dmem_wdata_o   (dmem_wdata_o),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o)
    );

endmodule

//--- verification/pipe_properties.sv
module pipe_properties (
    input logic                   clk,
    input logic                   rst,
    input logic                   imem_read_i,
    input pipe_pkg::addr_t        imem_addr_i,
    input logic                   imem_resp_i,
    input logic                   dmem_read_i,
    input logic                   dmem_write_i,
    input pipe_pkg::addr_t        dmem_addr_i,
    input pipe_pkg::word_t        dmem_wdata_i,
    input logic                   dmem_resp_i,
    input pipe_pkg::hazard_ctrl_t hazard_ctrl_i,
    input logic                   retire_valid_i,
    input pipe_pkg::retire_t      retire_i
);

    timeunit 1ns;
    timeprecision 1ps;

    logic dmem_req;

    assign dmem_req = dmem_read_i || dmem_write_i;

    // fetch address held until the response
    imem_req_stable: assert property (
        @(posedge clk) disable iff (rst)
        imem_read_i && !imem_resp_i |=> imem_read_i && $stable(imem_addr_i)
    ) else $error("fetch request changed before its response");

    dmem_req_stable: assert property (
        @(posedge clk) disable iff (rst)
        dmem_req && !dmem_resp_i |=> $stable(dmem_read_i) && $stable(dmem_write_i)
            && $stable(dmem_addr_i) && $stable(dmem_wdata_i)
    ) else $error("data request changed before its response");

    // nothing starts while reset is held
    reset_quiet: assert property (
        @(posedge clk)
        rst |-> !$rose(imem_read_i) && !$rose(dmem_req) && !$rose(retire_valid_i)
            && !$rose(|hazard_ctrl_i)
    ) else $error("strobe rose during reset");

    // back to back strobes belong to different instructions
    retire_single: assert property (
        @(posedge clk) disable iff (rst)
        retire_valid_i |=> !retire_valid_i || (retire_i.pc != $past(retire_i.pc))
    ) else $error("retire strobe held for the same instruction");

endmodule

bind pipe_top pipe_properties u_properties (
    .clk            (clk),
    .rst            (rst),
    .imem_read_i    (imem_read_o),
    .imem_addr_i    (imem_addr_o),
    .imem_resp_i    (imem_resp_i),
    .dmem_read_i    (dmem_read_o),
    .dmem_write_i   (dmem_write_o),
    .dmem_addr_i    (dmem_addr_o),
    .dmem_wdata_i   (dmem_wdata_o),
    .dmem_resp_i    (dmem_resp_i),
    .hazard_ctrl_i  (hazard_ctrl),
    .retire_valid_i (retire_valid_o),
    .retire_i       (retire_o)
);

//--- verification/pipe_tb.sv
module pipe_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int prog_len      = 64;
    localparam int dmem_depth    = 256;
    localparam int max_latency   = 5;
    localparam int reset_cycles  = 5;
    localparam int fetch_timeout = 20;
    localparam int run_timeout   = 5000;
    localparam int seed          = 44912;

    logic              clk;
    logic              rst;
    logic              imem_read_o;
    pipe_pkg::addr_t   imem_addr_o;
    logic              imem_resp_i;
    pipe_pkg::word_t   imem_rdata_i;
    logic              dmem_read_o;
    logic              dmem_write_o;
    pipe_pkg::addr_t   dmem_addr_o;
    pipe_pkg::word_t   dmem_wdata_o;
    logic              dmem_resp_i;
    pipe_pkg::word_t   dmem_rdata_i;
    logic              retire_valid_o;
    pipe_pkg::retire_t retire_o;

    pipe_pkg::word_t   prog        [prog_len];
    pipe_pkg::word_t   data_mem    [dmem_depth];
    pipe_pkg::word_t   model_mem   [dmem_depth];
    pipe_pkg::opcode_e exp_op      [prog_len];
    pipe_pkg::word_t   exp_result  [prog_len];
    pipe_pkg::addr_t   exp_addr_q  [$];
    pipe_pkg::word_t   exp_data_q  [$];
    bit                exp_write_q [$];

    int check_count [1:5];
    int error_count [1:5];
    int retired;
    bit timed_out;

    bit              ibusy;
    int              iwait;
    bit              dbusy;
    int              dwait;
    pipe_pkg::addr_t req_addr;
    pipe_pkg::word_t req_data;
    logic            req_write;

    pipe_top uut (
        .clk            (clk),
        .rst            (rst),
        .imem_read_o    (imem_read_o),
        .imem_addr_o    (imem_addr_o),
        .imem_resp_i    (imem_resp_i),
        .imem_rdata_i   (imem_rdata_i),
        .dmem_read_o    (dmem_read_o),
        .dmem_write_o   (dmem_write_o),
        .dmem_addr_o    (dmem_addr_o),
        .dmem_wdata_o   (dmem_wdata_o),
        .dmem_resp_i    (dmem_resp_i),
        .dmem_rdata_i   (dmem_rdata_i),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input int behavior, input string what,
                               input logic [31:0] got, input logic [31:0] exp);
        check_count[behavior]++;
        if (got !== exp) begin
            error_count[behavior]++;
            $display("ERR %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // every address bit shows up in the word
    function automatic pipe_pkg::word_t fill_word(input int idx);
        return 32'hc3000000 | (32'(idx) << 12) | (32'(idx) ^ 32'h0000005a);
    endfunction

    // past the program the memory returns ADD 0, 0
    function automatic pipe_pkg::word_t fetch_word(input pipe_pkg::addr_t addr);
        if (addr < 16'(prog_len * 4)) begin
            return prog[addr[7:2]];
        end
        return 32'h0;
    endfunction

    task automatic build_program();
        pipe_pkg::instr_t   ins;
        pipe_pkg::operand_t last_a;
        pipe_pkg::operand_t last_b;
        bit                 have_store;
        int                 i;
        have_store = 1'b0;
        last_a     = '0;
        last_b     = '0;
        for (i = 0; i < prog_len; i++) begin
            ins.unused = 14'($urandom);
            ins.a      = 8'($urandom);
            ins.b      = 8'($urandom);
            case (i)
                0: ins.opcode = pipe_pkg::OP_ADD;
                1: ins.opcode = pipe_pkg::OP_SUB;
                2: ins.opcode = pipe_pkg::OP_STORE;
                3: ins.opcode = pipe_pkg::OP_LOAD;
                default: ins.opcode = pipe_pkg::opcode_e'(2'($urandom_range(3, 0)));
            endcase
            // loads often read back the last stored address
            if (ins.opcode == pipe_pkg::OP_LOAD && have_store
                    && (i == 3 || $urandom_range(1, 0) == 1)) begin
                ins.a = last_a;
                ins.b = last_b;
            end
            if (ins.opcode == pipe_pkg::OP_STORE) begin
                have_store = 1'b1;
                last_a     = ins.a;
                last_b     = ins.b;
            end
            prog[i] = ins;
        end
    endtask

    // in-order execution over its own memory copy
    task automatic build_model();
        pipe_pkg::instr_t ins;
        pipe_pkg::addr_t  sum;
        pipe_pkg::addr_t  diff;
        int               i;
        for (i = 0; i < prog_len; i++) begin
            ins       = pipe_pkg::instr_t'(prog[i]);
            sum       = {8'h00, ins.a} + {8'h00, ins.b};
            diff      = {8'h00, ins.a} - {8'h00, ins.b};
            exp_op[i] = ins.opcode;
            case (ins.opcode)
                pipe_pkg::OP_ADD: exp_result[i] = {16'h0000, sum};
                pipe_pkg::OP_SUB: exp_result[i] = {16'h0000, diff};
                pipe_pkg::OP_LOAD: begin
                    exp_result[i] = model_mem[sum[7:0]];
                    exp_addr_q.push_back(sum);
                    exp_data_q.push_back(32'h0);
                    exp_write_q.push_back(1'b0);
                end
                default: begin
                    exp_result[i]        = {24'h000000, ins.b};
                    model_mem[sum[7:0]]  = {24'h000000, ins.b};
                    exp_addr_q.push_back(sum);
                    exp_data_q.push_back({24'h000000, ins.b});
                    exp_write_q.push_back(1'b1);
                end
            endcase
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            imem_resp_i <= 1'b0;
            ibusy = 1'b0;
        end else if (imem_resp_i) begin
            imem_resp_i <= 1'b0;
        end else if (imem_read_o) begin
            if (!ibusy) begin
                ibusy = 1'b1;
                iwait = $urandom_range(max_latency - 1, 0);
            end
            if (iwait == 0) begin
                imem_resp_i  <= 1'b1;
                imem_rdata_i <= fetch_word(imem_addr_o);
                ibusy = 1'b0;
            end else begin
                iwait--;
            end
        end
    end

    task automatic serve_data_request();
        pipe_pkg::addr_t e_addr;
        pipe_pkg::word_t e_data;
        bit              e_write;
        if (exp_addr_q.size() == 0) begin
            $display("unexpected data request at address %h", dmem_addr_o);
            error_count[4]++;
        end else begin
            e_addr  = exp_addr_q.pop_front();
            e_data  = exp_data_q.pop_front();
            e_write = exp_write_q.pop_front();
            check_value(4, "data address", 32'(dmem_addr_o), 32'(e_addr));
            check_value(4, "data write flag", 32'(dmem_write_o), 32'(e_write));
            if (e_write) begin
                check_value(4, "store data", dmem_wdata_o, e_data);
            end
        end
        if (dmem_write_o) begin
            data_mem[dmem_addr_o[7:0]] = dmem_wdata_o;
        end
        dmem_rdata_i <= data_mem[dmem_addr_o[7:0]];
        dmem_resp_i  <= 1'b1;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            dmem_resp_i <= 1'b0;
            dbusy = 1'b0;
        end else if (dmem_resp_i) begin
            dmem_resp_i <= 1'b0;
        end else if (dmem_read_o || dmem_write_o) begin
            if (!dbusy) begin
                dbusy     = 1'b1;
                dwait     = $urandom_range(max_latency - 1, 0);
                req_addr  = dmem_addr_o;
                req_data  = dmem_wdata_o;
                req_write = dmem_write_o;
            end else begin
                // the pipeline is frozen behind the request
                check_value(5, "retire during stall", 32'(retire_valid_o), 32'h0);
                check_value(5, "stalled address", 32'(dmem_addr_o), 32'(req_addr));
                check_value(5, "stalled data", dmem_wdata_o, req_data);
                check_value(5, "stalled write flag", 32'(dmem_write_o), 32'(req_write));
            end
            if (dwait == 0) begin
                serve_data_request();
                dbusy = 1'b0;
            end else begin
                dwait--;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && retire_valid_o && retired < prog_len) begin
            check_value(2, "retired pc", 32'(retire_o.pc), 32'(retired * 4));
            check_value(2, "retired opcode", 32'(retire_o.opcode), 32'(exp_op[retired]));
            if (exp_op[retired] == pipe_pkg::OP_ADD || exp_op[retired] == pipe_pkg::OP_SUB) begin
                check_value(3, "alu result", retire_o.result, exp_result[retired]);
            end else begin
                check_value(4, "memory result", retire_o.result, exp_result[retired]);
            end
            retired++;
        end
    end

    task automatic reset_phase();
        int cyc;
        for (cyc = 1; cyc <= reset_cycles; cyc++) begin
            @(posedge clk);
            // outputs settle after the first edge
            if (cyc > 1) begin
                check_value(1, "imem_read_o in reset", 32'(imem_read_o), 32'h0);
                check_value(1, "dmem_read_o in reset", 32'(dmem_read_o), 32'h0);
                check_value(1, "dmem_write_o in reset", 32'(dmem_write_o), 32'h0);
                check_value(1, "retire_valid_o in reset", 32'(retire_valid_o), 32'h0);
            end
        end
        rst <= 1'b0;
    endtask

    task automatic wait_first_fetch();
        int n;
        bit seen;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < fetch_timeout) begin
            @(posedge clk);
            n++;
            if (imem_read_o) begin
                seen = 1'b1;
                check_value(1, "first fetch address", 32'(imem_addr_o), 32'h0);
            end
        end
        if (!seen) begin
            $display("timeout: no instruction fetch within %0d cycles of reset", fetch_timeout);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_all_retired();
        int n;
        n = 0;
        while (retired < prog_len && n < run_timeout) begin
            @(negedge clk);
            n++;
        end
        if (retired < prog_len) begin
            $display("timeout: only %0d of %0d instructions retired", retired, prog_len);
            timed_out = 1'b1;
        end
    endtask

    task automatic print_behavior(input int b, input string name);
        $display("behavior %0d, %s: %0d checks, %0d errors",
                 b, name, check_count[b], error_count[b]);
    endtask

    task automatic report_run();
        int total_checks;
        int total_errors;
        int b;
        total_checks = 0;
        total_errors = 0;
        for (b = 1; b <= 5; b++) begin
            total_checks += check_count[b];
            total_errors += error_count[b];
        end
        $display("%0d checks, %0d errors, %0d of %0d instructions retired",
                 total_checks, total_errors, retired, prog_len);
        if (!timed_out && total_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    initial begin
        int i;
        void'($urandom(seed));
        rst          = 1'b1;
        imem_resp_i  = 1'b0;
        imem_rdata_i = '0;
        dmem_resp_i  = 1'b0;
        dmem_rdata_i = '0;
        timed_out    = 1'b0;
        retired      = 0;
        ibusy        = 1'b0;
        dbusy        = 1'b0;
        for (i = 0; i < dmem_depth; i++) begin
            data_mem[i]  = fill_word(i);
            model_mem[i] = fill_word(i);
        end
        build_program();
        build_model();
        reset_phase();
        wait_first_fetch();
        print_behavior(1, "reset levels and first fetch");
        if (!timed_out) begin
            wait_all_retired();
        end
        if (!timed_out && exp_addr_q.size() != 0) begin
            $display("%0d data requests were never issued", exp_addr_q.size());
            error_count[4]++;
        end
        print_behavior(2, "pc order under fetch latency");
        print_behavior(3, "add and sub results");
        print_behavior(4, "stores and loads");
        print_behavior(5, "data memory stalls");
        report_run();
    end

endmodule

//--- flist.f
hdl/pipe_pkg.sv
hdl/fetch_unit.sv
hdl/hazard_ctrl_unit.sv
hdl/execute_unit.sv
hdl/mem_access_unit.sv
hdl/pipe_top.sv
verification/pipe_properties.sv
verification/pipe_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module pipe_tb -f flist.f || exit 1
out=$(./obj_dir/Vpipe_tb 2>&1)
echo "$out"
echo "$out" | grep -q -F '*** TEST PASSED ***' && exit 0 || exit 1
